// File: logic/seq_consts.svh
// Vector sequencer constants

`ifndef SEQ_CONSTS_SVH
`define SEQ_CONSTS_SVH

// Lanes and processing elements
`define NR_LANES 4
`define NR_PES 8
`define NR_VFUS 6
// Instruction IDs in flight
`define NR_VINSN 8
// Register file
`define NR_VREGS 32
`define VMASK_REG 0
// Instruction queue depths, one per functional unit
`define VALU_DEPTH 4
`define VMFPU_DEPTH 4
`define VSLDU_DEPTH 2
`define VMASKU_DEPTH 2
`define VLDU_DEPTH 2
`define VSTU_DEPTH 2
// PE index offsets after the lanes
`define OFFSET_LOAD 0
`define OFFSET_STORE 1
`define OFFSET_SLIDE 2
`define OFFSET_MASK 3

`endif

// File: logic/seq_pkg.sv
// Vector sequencer types

`include "seq_consts.svh"

package seq_pkg;

  typedef enum logic [3:0] {
    VADD, VSUB, VMUL, VMSEQ, VLE, VSE, VSLIDEUP, VSLIDEDOWN, VMV_XS
  } vec_op_e;

  // Order matches the queue depth table
  typedef enum logic [2:0] {
    VFU_ALU, VFU_MFPU, VFU_SLIDE, VFU_MASK, VFU_LOAD, VFU_STORE
  } vfu_e;

  typedef logic [2:0]           vid_t;
  typedef logic [`NR_VINSN-1:0] vid_mask_t;
  typedef logic [4:0]           vreg_t;

  typedef struct packed {
    vec_op_e     op;
    vreg_t       vs1;
    logic        use_vs1;
    vreg_t       vs2;
    logic        use_vs2;
    vreg_t       vd;
    logic        use_vd;
    logic        use_vd_op;
    // Low means masked by v0
    logic        vm;
    logic [15:0] vl;
    logic [31:0] scalar_op;
  } seq_req_t;

  typedef struct packed {
    vid_t      id;
    vfu_e      vfu;
    seq_req_t  req;
    vid_mask_t hazard_vs1;
    vid_mask_t hazard_vs2;
    vid_mask_t hazard_vm;
    vid_mask_t hazard_vd;
  } pe_req_t;

  typedef struct packed {
    logic [31:0] resp;
    logic        error;
  } seq_resp_t;

  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  // Main unit of an operation
  function automatic vfu_e unit_of(vec_op_e op);
    unique case (op)
      VMUL:                 unit_of = VFU_MFPU;
      VMSEQ:                unit_of = VFU_MASK;
      VLE:                  unit_of = VFU_LOAD;
      VSE:                  unit_of = VFU_STORE;
      VSLIDEUP, VSLIDEDOWN: unit_of = VFU_SLIDE;
      default:              unit_of = VFU_ALU;
    endcase
  endfunction

  // Every queue the operation occupies
  function automatic logic [`NR_VFUS-1:0] target_units(vec_op_e op);
    target_units = '0;
    target_units[unit_of(op)] = 1'b1;
    // Compares run on the ALU and are packed by the mask unit
    if (op == VMSEQ) target_units[VFU_ALU] = 1'b1;
  endfunction

  function automatic logic is_mem(vec_op_e op);
    is_mem = (op == VLE) || (op == VSE);
  endfunction

  function automatic logic needs_answer(vec_op_e op);
    needs_answer = is_mem(op) || (op == VMV_XS);
  endfunction

endpackage

// File: logic/vinsn_tracker.sv
// Running instruction tracker

`include "seq_consts.svh"

module vinsn_tracker import seq_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  vid_mask_t [`NR_PES-1:0]     pe_done_i,
  input  logic                        issue_i,
  input  vid_t                        issue_id_i,
  input  vfu_e                        issue_unit_i,
  input  logic                        issue_masked_i,
  output vid_mask_t                   running_o,
  output vid_mask_t                   running_next_o,
  output vid_t                        next_id_o,
  output logic                        full_o,
  output logic                        idle_o
);

  // One row per PE, one bit per ID
  vid_mask_t [`NR_PES-1:0] pe_run_d, pe_run_q;
  vid_mask_t               running_q;

  //////////////////////////////////////////////////
  // Matrix update
  //////////////////////////////////////////////////

  always_comb begin
    pe_run_d = pe_run_q;
    // Finished IDs leave their PE
    for (int pe = 0; pe < `NR_PES; pe++) begin
      pe_run_d[pe] &= ~pe_done_i[pe];
    end
    if (issue_i) begin
      unique case (issue_unit_i)
        VFU_LOAD:  pe_run_d[`NR_LANES + `OFFSET_LOAD][issue_id_i] = 1'b1;
        VFU_STORE: pe_run_d[`NR_LANES + `OFFSET_STORE][issue_id_i] = 1'b1;
        VFU_SLIDE: pe_run_d[`NR_LANES + `OFFSET_SLIDE][issue_id_i] = 1'b1;
        VFU_MASK:  pe_run_d[`NR_LANES + `OFFSET_MASK][issue_id_i] = 1'b1;
        // ALU and MFPU work spreads over every lane
        default: begin
          for (int l = 0; l < `NR_LANES; l++) begin
            pe_run_d[l][issue_id_i] = 1'b1;
          end
        end
      endcase
      // Masked ops also pass through the mask unit
      if (issue_masked_i) pe_run_d[`NR_LANES + `OFFSET_MASK][issue_id_i] = 1'b1;
    end
  end

  // ID runs while any PE still holds it
  always_comb begin
    running_next_o = '0;
    for (int pe = 0; pe < `NR_PES; pe++) begin
      running_next_o |= pe_run_d[pe];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_run_q  <= '0;
      running_q <= '0;
    end else begin
      pe_run_q  <= pe_run_d;
      running_q <= running_next_o;
    end
  end

  //////////////////////////////////////////////////
  // Free ID search
  //////////////////////////////////////////////////

  // Lowest clear bit wins
  always_comb begin
    next_id_o = '0;
    for (int i = `NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) next_id_o = vid_t'(i);
    end
  end

  assign full_o    = &running_q;
  assign idle_o    = ~|running_q;
  assign running_o = running_q;

  // Issue only hands out IDs that are truly free
  a_issue_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_i |-> !full_o && !running_q[issue_id_i]);

endmodule

// File: logic/vreg_scoreboard.sv
// Vector register scoreboard

`include "seq_consts.svh"

module vreg_scoreboard import seq_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  seq_req_t  req_i,
  input  vid_mask_t running_i,
  input  logic      issue_i,
  input  vid_t      issue_id_i,
  output vid_mask_t hazard_vs1_o,
  output vid_mask_t hazard_vs2_o,
  output vid_mask_t hazard_vm_o,
  output vid_mask_t hazard_vd_o
);

  // Last reader and last writer of every register
  vreg_access_t [`NR_VREGS-1:0] read_list_d, read_list_q;
  vreg_access_t [`NR_VREGS-1:0] write_list_d, write_list_q;
  vreg_access_t [`NR_VREGS-1:0] read_clean, write_clean;
  vid_mask_t                    war_bits;

  // One-hot ID of a live entry
  function automatic vid_mask_t vid_bit(vreg_access_t a);
    vid_bit = '0;
    if (a.valid) vid_bit[a.vid] = 1'b1;
  endfunction

  // Drop entries whose ID has finished
  always_comb begin
    read_clean  = read_list_q;
    write_clean = write_list_q;
    for (int v = 0; v < `NR_VREGS; v++) begin
      read_clean[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
      write_clean[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end
  end

  //////////////////////////////////////////////////
  // Hazards of the pending request
  //////////////////////////////////////////////////

  // Readers still in flight on the destination
  assign war_bits = req_i.use_vd ? vid_bit(read_clean[req_i.vd]) : '0;

  always_comb begin
    hazard_vs1_o = war_bits;
    hazard_vs2_o = war_bits;
    hazard_vm_o  = war_bits;
    hazard_vd_o  = '0;
    // RAW on each source
    if (req_i.use_vs1) hazard_vs1_o |= vid_bit(write_clean[req_i.vs1]);
    if (req_i.use_vs2) hazard_vs2_o |= vid_bit(write_clean[req_i.vs2]);
    if (!req_i.vm) hazard_vm_o |= vid_bit(write_clean[`VMASK_REG]);
    // WAW on the destination
    if (req_i.use_vd) hazard_vd_o = vid_bit(write_clean[req_i.vd]);
  end

  //////////////////////////////////////////////////
  // List update on issue
  //////////////////////////////////////////////////

  always_comb begin
    read_list_d  = read_clean;
    write_list_d = write_clean;
    if (issue_i) begin
      if (req_i.use_vd) write_list_d[req_i.vd] = '{vid: issue_id_i, valid: 1'b1};
      if (req_i.use_vs1) read_list_d[req_i.vs1] = '{vid: issue_id_i, valid: 1'b1};
      if (req_i.use_vs2) read_list_d[req_i.vs2] = '{vid: issue_id_i, valid: 1'b1};
      // Mask source counts as a read of v0
      if (!req_i.vm) read_list_d[`VMASK_REG] = '{vid: issue_id_i, valid: 1'b1};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
    end else begin
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
    end
  end

endmodule

// File: logic/vfu_queue_credits.sv
// Functional unit queue occupancy

`include "seq_consts.svh"

module vfu_queue_credits import seq_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  vec_op_e                 req_op_i,
  input  logic                    accept_i,
  input  vid_mask_t [`NR_PES-1:0] pe_done_i,
  input  logic                    alu_done_i,
  input  logic                    mfpu_done_i,
  output logic                    has_room_o
);

  localparam int unsigned CNT_W = $clog2(`VALU_DEPTH + 1);
  // Indexed by vfu_e
  localparam int unsigned DEPTH [`NR_VFUS] = '{
    `VALU_DEPTH, `VMFPU_DEPTH, `VSLDU_DEPTH, `VMASKU_DEPTH, `VLDU_DEPTH, `VSTU_DEPTH
  };

  logic [`NR_VFUS-1:0][CNT_W-1:0] cnt_q;
  logic [`NR_VFUS-1:0]            targets;
  logic [`NR_VFUS-1:0]            done;
  logic [`NR_VFUS-1:0]            below;

  assign targets = target_units(req_op_i);

  // Lane units report on their own strobes, the rest on any done bit of their PE
  assign done[VFU_ALU]   = alu_done_i;
  assign done[VFU_MFPU]  = mfpu_done_i;
  assign done[VFU_SLIDE] = |pe_done_i[`NR_LANES + `OFFSET_SLIDE];
  assign done[VFU_MASK]  = |pe_done_i[`NR_LANES + `OFFSET_MASK];
  assign done[VFU_LOAD]  = |pe_done_i[`NR_LANES + `OFFSET_LOAD];
  assign done[VFU_STORE] = |pe_done_i[`NR_LANES + `OFFSET_STORE];

  for (genvar i = 0; i < `NR_VFUS; i++) begin : g_cnt
    logic up;

    assign up       = accept_i & targets[i];
    assign below[i] = cnt_q[i] < DEPTH[i];

    // Up and down together leave the count unchanged
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q[i] <= '0;
      end else if (up && !done[i]) begin
        cnt_q[i] <= cnt_q[i] + CNT_W'(1);
      end else if (done[i] && !up && cnt_q[i] != '0) begin
        cnt_q[i] <= cnt_q[i] - CNT_W'(1);
      end
    end

    // Acceptance never pushes a queue past its depth
    a_cnt_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
      cnt_q[i] <= DEPTH[i]);
  end

  // Every targeted queue needs a free slot
  assign has_room_o = &(~targets | below);

endmodule

// File: logic/issue_ctrl.sv
// Issue control and dispatcher handshake

module issue_ctrl import seq_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  seq_req_t    req_i,
  input  logic        req_valid_i,
  input  vid_mask_t   hazard_vs1_i,
  input  vid_mask_t   hazard_vs2_i,
  input  vid_mask_t   hazard_vm_i,
  input  vid_mask_t   hazard_vd_i,
  input  vid_mask_t   running_next_i,
  input  vid_t        next_id_i,
  input  logic        full_i,
  input  logic        has_room_i,
  input  logic        pe_req_ready_i,
  input  logic        addrgen_ack_i,
  input  logic        addrgen_error_i,
  input  logic [31:0] scalar_resp_i,
  input  logic        scalar_resp_valid_i,
  output logic        req_ready_o,
  output seq_resp_t   resp_o,
  output logic        resp_valid_o,
  output pe_req_t     pe_req_o,
  output logic        pe_req_valid_o,
  output logic        issue_o,
  output vid_t        issue_id_o,
  output vfu_e        issue_unit_o,
  output logic        issue_masked_o
);

  typedef enum logic {IDLE, WAIT} state_e;

  state_e  state_d, state_q;
  pe_req_t pe_req_d;
  logic    pe_req_valid_d;
  logic    held;
  logic    no_operands;
  logic    stall;
  logic    can_issue;

  // PE side has not taken the registered request yet
  assign held = pe_req_valid_o && !pe_req_ready_i;

  //////////////////////////////////////////////////
  // Stall rules
  //////////////////////////////////////////////////

  assign no_operands = !(req_i.use_vs1 || req_i.use_vs2 || req_i.use_vd_op || !req_i.vm);

  always_comb begin
    stall = no_operands && |{hazard_vs1_i, hazard_vs2_i, hazard_vm_i, hazard_vd_i};
    // Slides cannot be chained on their data operands
    if (req_i.op == VSLIDEUP) stall |= |{hazard_vs1_i, hazard_vs2_i, hazard_vd_i};
    if (req_i.op == VSLIDEDOWN) stall |= |{hazard_vs1_i, hazard_vs2_i};
  end

  assign can_issue = req_valid_i && has_room_i && !full_i && !stall;

  assign issue_o        = (state_q == IDLE) && !held && can_issue;
  assign issue_id_o     = next_id_i;
  assign issue_unit_o   = unit_of(req_i.op);
  assign issue_masked_o = !req_i.vm;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d        = state_q;
    resp_o         = '0;
    resp_valid_o   = 1'b0;
    req_ready_o    = 1'b1;
    pe_req_valid_d = held;
    // Keep the payload, drop hazards on finished IDs
    pe_req_d            = pe_req_o;
    pe_req_d.hazard_vs1 = pe_req_o.hazard_vs1 & running_next_i;
    pe_req_d.hazard_vs2 = pe_req_o.hazard_vs2 & running_next_i;
    pe_req_d.hazard_vm  = pe_req_o.hazard_vm & running_next_i;
    pe_req_d.hazard_vd  = pe_req_o.hazard_vd & running_next_i;

    unique case (state_q)
      IDLE: begin
        if (held) begin
          req_ready_o = 1'b0;
        end else if (req_valid_i) begin
          req_ready_o = can_issue;
          if (can_issue) begin
            pe_req_d = '{
              id:         next_id_i,
              vfu:        unit_of(req_i.op),
              req:        req_i,
              hazard_vs1: hazard_vs1_i,
              hazard_vs2: hazard_vs2_i,
              hazard_vm:  hazard_vm_i,
              hazard_vd:  hazard_vd_i
            };
            pe_req_valid_d = 1'b1;
            // Handshake completes only once the answer is back
            if (needs_answer(req_i.op)) begin
              req_ready_o = 1'b0;
              state_d     = WAIT;
            end
          end
        end
      end

      WAIT: begin
        req_ready_o = 1'b0;
        // Address translation done
        if (is_mem(pe_req_o.req.op) && addrgen_ack_i) begin
          state_d      = IDLE;
          req_ready_o  = 1'b1;
          resp_valid_o = 1'b1;
          resp_o.error = addrgen_error_i;
        end
        // Scalar result back from the PEs
        if (pe_req_o.req.op == VMV_XS && scalar_resp_valid_i) begin
          state_d      = IDLE;
          req_ready_o  = 1'b1;
          resp_valid_o = 1'b1;
          resp_o.resp  = scalar_resp_i;
        end
      end

      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      pe_req_valid_o <= pe_req_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    pe_req_o <= pe_req_d;
  end

  // A held request keeps its payload, only hazard bits may change
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    held |=> pe_req_valid_o && $stable(pe_req_o.id) && $stable(pe_req_o.vfu) &&
             $stable(pe_req_o.req));

endmodule

// File: logic/vector_sequencer.sv
// Vector instruction sequencer

`include "seq_consts.svh"

module vector_sequencer import seq_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Dispatcher
  input  seq_req_t                req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,
  output seq_resp_t               resp_o,
  output logic                    resp_valid_o,
  output logic                    idle_o,
  // Processing elements
  output pe_req_t                 pe_req_o,
  output logic                    pe_req_valid_o,
  input  logic                    pe_req_ready_i,
  input  vid_mask_t [`NR_PES-1:0] pe_done_i,
  input  logic                    alu_done_i,
  input  logic                    mfpu_done_i,
  input  logic [31:0]             scalar_resp_i,
  input  logic                    scalar_resp_valid_i,
  // Address generator
  input  logic                    addrgen_ack_i,
  input  logic                    addrgen_error_i
);

  vid_mask_t running_q, running_d;
  vid_t      next_id, issue_id;
  logic      full, has_room, issue, issue_masked;
  vfu_e      issue_unit;
  vid_mask_t hazard_vs1, hazard_vs2, hazard_vm, hazard_vd;

  vinsn_tracker i_tracker (
    .clk_i, .rst_ni, .pe_done_i,
    .issue_i        (issue),
    .issue_id_i     (issue_id),
    .issue_unit_i   (issue_unit),
    .issue_masked_i (issue_masked),
    .running_o      (running_q),
    .running_next_o (running_d),
    .next_id_o      (next_id),
    .full_o         (full),
    .idle_o
  );

  vreg_scoreboard i_scoreboard (
    .clk_i, .rst_ni, .req_i,
    .running_i    (running_q),
    .issue_i      (issue),
    .issue_id_i   (issue_id),
    .hazard_vs1_o (hazard_vs1),
    .hazard_vs2_o (hazard_vs2),
    .hazard_vm_o  (hazard_vm),
    .hazard_vd_o  (hazard_vd)
  );

  vfu_queue_credits i_credits (
    .clk_i, .rst_ni, .pe_done_i, .alu_done_i, .mfpu_done_i,
    .req_op_i   (req_i.op),
    .accept_i   (issue),
    .has_room_o (has_room)
  );

  issue_ctrl i_issue (
    .clk_i, .rst_ni, .req_i, .req_valid_i,
    .hazard_vs1_i   (hazard_vs1),
    .hazard_vs2_i   (hazard_vs2),
    .hazard_vm_i    (hazard_vm),
    .hazard_vd_i    (hazard_vd),
    .running_next_i (running_d),
    .next_id_i      (next_id),
    .full_i         (full),
    .has_room_i     (has_room),
    .pe_req_ready_i, .addrgen_ack_i, .addrgen_error_i,
    .scalar_resp_i, .scalar_resp_valid_i,
    .req_ready_o, .resp_o, .resp_valid_o, .pe_req_o, .pe_req_valid_o,
    .issue_o        (issue),
    .issue_id_o     (issue_id),
    .issue_unit_o   (issue_unit),
    .issue_masked_o (issue_masked)
  );

endmodule

// File: dv/tb_vector_sequencer.sv
// Vector sequencer testbench

`include "seq_consts.svh"

module tb_vector_sequencer import seq_pkg::*; ;

  logic                    clk, rst_n;
  seq_req_t                req;
  logic                    req_valid, req_ready;
  seq_resp_t               resp;
  logic                    resp_valid, idle;
  pe_req_t                 pe_req;
  logic                    pe_req_valid, pe_req_ready;
  vid_mask_t [`NR_PES-1:0] pe_done;
  logic                    alu_done, mfpu_done;
  logic [31:0]             scalar_resp;
  logic                    scalar_resp_valid, addrgen_ack, addrgen_error;

  int          errors, checks, cycles, limit, step;
  logic [31:0] seed;
  string       lines[$];
  // Fields of the current step
  string       kind;
  logic [31:0] f_op, f_vs1, f_vs2, f_vd, f_use, f_vm, f_bp, f_a, f_b;
  logic [31:0] f_h1, f_h2, f_hm, f_hd, f_idle, f_val, f_err;

  vector_sequencer dut (
    .clk_i (clk), .rst_ni (rst_n),
    .req_i (req), .req_valid_i (req_valid), .req_ready_o (req_ready),
    .resp_o (resp), .resp_valid_o (resp_valid), .idle_o (idle),
    .pe_req_o (pe_req), .pe_req_valid_o (pe_req_valid), .pe_req_ready_i (pe_req_ready),
    .pe_done_i (pe_done), .alu_done_i (alu_done), .mfpu_done_i (mfpu_done),
    .scalar_resp_i (scalar_resp), .scalar_resp_valid_i (scalar_resp_valid),
    .addrgen_ack_i (addrgen_ack), .addrgen_error_i (addrgen_error)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run length bound of 40 cycles per step
  always @(posedge clk) begin
    cycles++;
    if (limit != 0 && cycles > limit) begin
      $display("Timeout after %0d cycles, DUT stopped responding", cycles);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    return x;
  endfunction

  task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  function automatic string tag(string what);
    return $sformatf("step %0d %s %s", step, kind, what);
  endfunction

  ////////////////////////////////////////////////////
  // Step tasks
  ////////////////////////////////////////////////////

  task automatic drive_request();
    seq_req_t r;
    r           = '0;
    r.op        = vec_op_e'(f_op[3:0]);
    r.vs1       = f_vs1[4:0];
    r.use_vs1   = f_use[3];
    r.vs2       = f_vs2[4:0];
    r.use_vs2   = f_use[2];
    r.vd        = f_vd[4:0];
    r.use_vd    = f_use[1];
    r.use_vd_op = f_use[0];
    r.vm        = f_vm[0];
    r.vl        = 16'd16;
    @(posedge clk);
    req       <= r;
    req_valid <= 1'b1;
  endtask

  task automatic release_pe();
    @(posedge clk);
    pe_req_ready <= 1'b1;
    @(posedge clk);
    pe_req_ready <= 1'b0;
    @(negedge clk);
    check_value(tag("pe_req_valid dropped"), 0, pe_req_valid);
  endtask

  task automatic run_request();
    int   hold;
    logic answer;
    // Loads, stores and VMV_XS keep the dispatcher waiting
    answer = (f_op == 4) || (f_op == 5) || (f_op == 8);
    drive_request();
    @(negedge clk);
    while (!pe_req_valid) @(negedge clk);
    check_value(tag("id"), f_a, pe_req.id);
    check_value(tag("op"), f_op, pe_req.req.op);
    check_value(tag("hazard_vs1"), f_h1, pe_req.hazard_vs1);
    check_value(tag("hazard_vs2"), f_h2, pe_req.hazard_vs2);
    check_value(tag("hazard_vm"), f_hm, pe_req.hazard_vm);
    check_value(tag("hazard_vd"), f_hd, pe_req.hazard_vd);
    @(posedge clk);
    if (!answer) req_valid <= 1'b0;
    if (f_bp != 0) begin
      // Request stays held through and after the back-pressure window
      seed = xorshift(seed);
      hold = int'(seed % 4) + 1;
      repeat (hold) begin
        @(negedge clk);
        check_value(tag("held req_ready"), 0, req_ready);
        check_value(tag("held valid"), 1, pe_req_valid);
        check_value(tag("held id"), f_a, pe_req.id);
        check_value(tag("held op"), f_op, pe_req.req.op);
      end
    end else begin
      release_pe();
    end
  endtask

  // Request must stay refused for a while
  task automatic run_refuse();
    drive_request();
    repeat (4) begin
      @(negedge clk);
      check_value(tag("not issued"), 0, pe_req_valid);
      check_value(tag("req_ready"), 0, req_ready);
    end
  endtask

  task automatic run_done();
    vid_mask_t [`NR_PES-1:0] d;
    d = '0;
    for (int pe = 0; pe < `NR_PES; pe++) begin
      if (f_a[pe]) d[pe][f_b[2:0]] = 1'b1;
    end
    @(posedge clk);
    pe_done   <= d;
    alu_done  <= f_val[0];
    mfpu_done <= f_val[1];
    @(posedge clk);
    pe_done   <= '0;
    alu_done  <= 1'b0;
    mfpu_done <= 1'b0;
    @(negedge clk);
    check_value(tag("idle"), f_idle, idle);
    if (f_bp != 0) begin
      check_value(tag("still held"), 1, pe_req_valid);
      check_value(tag("held hazard_vs1"), f_h1, pe_req.hazard_vs1);
      check_value(tag("held hazard_vs2"), f_h2, pe_req.hazard_vs2);
      check_value(tag("held hazard_vm"), f_hm, pe_req.hazard_vm);
      check_value(tag("held hazard_vd"), f_hd, pe_req.hazard_vd);
    end
  endtask

  // Ack or scalar result ends the wait in the same cycle
  task automatic run_answer(logic scalar);
    @(negedge clk);
    check_value(tag("waiting req_ready"), 0, req_ready);
    @(posedge clk);
    if (scalar) begin
      scalar_resp       <= f_val;
      scalar_resp_valid <= 1'b1;
    end else begin
      addrgen_ack   <= 1'b1;
      addrgen_error <= f_err[0];
    end
    @(negedge clk);
    check_value(tag("resp_valid"), 1, resp_valid);
    check_value(tag("req_ready"), 1, req_ready);
    if (scalar) check_value(tag("resp"), f_val, resp.resp);
    else check_value(tag("error"), f_err, resp.error);
    @(posedge clk);
    scalar_resp_valid <= 1'b0;
    addrgen_ack       <= 1'b0;
    addrgen_error     <= 1'b0;
    req_valid         <= 1'b0;
  endtask

  ////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////

  initial begin
    int    fd;
    int    rc;
    string line;
    rst_n = 1'b0;
    req = '0;
    req_valid = 1'b0;
    pe_req_ready = 1'b0;
    pe_done = '0;
    alu_done = 1'b0;
    mfpu_done = 1'b0;
    scalar_resp = '0;
    scalar_resp_valid = 1'b0;
    addrgen_ack = 1'b0;
    addrgen_error = 1'b0;
    errors = 0;
    checks = 0;
    cycles = 0;
    limit = 0;
    seed = 32'habea_fede;

    fd = $fopen("dv/seq_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stimulus file dv/seq_input.txt");
      $display("=== FAIL ===");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        rc = $fgets(line, fd);
        if (rc > 3 && line.getc(0) != 8'h23) lines.push_back(line);
      end
      $fclose(fd);
      limit = 40 * lines.size();

      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      kind = "reset";
      check_value(tag("req_ready"), 1, req_ready);
      check_value(tag("pe_req_valid"), 0, pe_req_valid);
      check_value(tag("resp_valid"), 0, resp_valid);
      check_value(tag("idle"), 1, idle);

      foreach (lines[i]) begin
        step = i;
        rc = $sscanf(lines[i], "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", kind,
                     f_op, f_vs1, f_vs2, f_vd, f_use, f_vm, f_bp, f_a, f_b,
                     f_h1, f_h2, f_hm, f_hd, f_idle, f_val, f_err);
        if (kind == "req") run_request();
        else if (kind == "refuse") run_refuse();
        else if (kind == "done") run_done();
        else if (kind == "release") release_pe();
        else if (kind == "ack") run_answer(1'b0);
        else if (kind == "scalar") run_answer(1'b1);
        else begin
          $display("Unknown step kind %s on step %0d", kind, i);
          errors++;
        end
      end

      $display("checks %0d errors %0d", checks, errors);
      if (errors == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

endmodule

// File: dv/seq_input.txt
# kind op vs1 vs2 vd use(vs1,vs2,vd,vd_op) vm bp a b h1 h2 hm hd idle val err  (hex)
# req: a=id  done: a=PE mask b=id val={mfpu,alu} bp=check held  ack: err  scalar: val
req     0 01 02 03 e 1 0 0  0 00 00 00 00 0 0        0
req     1 03 00 04 a 1 0 1  0 01 00 00 00 0 0        0
req     0 05 06 01 e 1 0 2  0 01 01 01 00 0 0        0
req     2 07 08 03 e 1 0 3  0 02 02 02 01 0 0        0
done    0 00 00 00 0 1 0 0f 0 00 00 00 00 0 1        0
req     0 09 0a 00 e 1 0 0  0 00 00 00 00 0 0        0
req     0 0c 0d 0b e 0 1 4  0 00 00 01 00 0 0        0
done    0 00 00 00 0 1 1 0f 0 00 00 00 00 0 1        0
release 0 00 00 00 0 1 0 0  0 00 00 00 00 0 0        0
done    0 00 00 00 0 1 0 0f 1 00 00 00 00 0 1        0
done    0 00 00 00 0 1 0 0f 2 00 00 00 00 0 1        0
done    0 00 00 00 0 1 0 0f 3 00 00 00 00 0 2        0
done    0 00 00 00 0 1 0 8f 4 00 00 00 00 1 1        0
req     4 00 00 05 2 1 0 0  0 00 00 00 00 0 0        0
ack     0 00 00 00 0 1 0 0  0 00 00 00 00 0 0        0
done    0 00 00 00 0 1 0 10 0 00 00 00 00 1 0        0
req     5 00 05 00 4 1 0 0  0 00 00 00 00 0 0        0
ack     0 00 00 00 0 1 0 0  0 00 00 00 00 0 0        1
done    0 00 00 00 0 1 0 20 0 00 00 00 00 1 0        0
req     8 00 07 00 4 1 0 0  0 00 00 00 00 0 0        0
scalar  0 00 00 00 0 1 0 0  0 00 00 00 00 0 deadbeef 0
done    0 00 00 00 0 1 0 0f 0 00 00 00 00 1 1        0
req     7 00 15 14 6 1 0 0  0 00 00 00 00 0 0        0
req     7 00 17 16 6 1 0 1  0 00 00 00 00 0 0        0
refuse  7 00 19 18 6 1 0 0  0 00 00 00 00 0 0        0
done    0 00 00 00 0 1 0 40 0 00 00 00 00 0 0        0
req     7 00 19 18 6 1 0 0  0 00 00 00 00 0 0        0
done    0 00 00 00 0 1 0 40 1 00 00 00 00 0 0        0
done    0 00 00 00 0 1 0 40 0 00 00 00 00 1 0        0
req     0 1b 1c 1a e 1 0 0  0 00 00 00 00 0 0        0
refuse  6 00 1d 1a 6 1 0 0  0 00 00 00 00 0 0        0
done    0 00 00 00 0 1 0 0f 0 00 00 00 00 1 1        0
req     6 00 1d 1a 6 1 0 0  0 00 00 00 00 0 0        0
done    0 00 00 00 0 1 0 40 0 00 00 00 00 1 0        0

// File: src.f
+incdir+logic
logic/seq_pkg.sv
logic/vinsn_tracker.sv
logic/vreg_scoreboard.sv
logic/vfu_queue_credits.sv
logic/issue_ctrl.sv
logic/vector_sequencer.sv
dv/tb_vector_sequencer.sv

// File: Bender.yml
package:
  name: vector_sequencer

sources:
  - include_dirs:
      - logic
    files:
      - logic/seq_pkg.sv
      - logic/vinsn_tracker.sv
      - logic/vreg_scoreboard.sv
      - logic/vfu_queue_credits.sv
      - logic/issue_ctrl.sv
      - logic/vector_sequencer.sv
  - target: test
    include_dirs:
      - logic
    files:
      - dv/tb_vector_sequencer.sv
